// ==== common/cache_types_pkg.sv ====
package cache_types_pkg;

    localparam int WORD_W      = 32;
    localparam int ADDR_W      = 32;
    localparam int BLOCK_WORDS = 4;
    localparam int OFFSET_W    = 2;  // Word select within a block
    localparam int BYTE_OFF_W  = 2;
    localparam int UUID_W      = 4;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [UUID_W-1:0] uuid_t;

    typedef enum logic [2:0] {
        IDLE,
        BLOCK_PULL,
        VICTIM_EJECT,
        FINISH,
        FLUSH,
        WRITEBACK,
        HALTED
    } bank_state_t;

endpackage

// ==== design/mshr_buffer.sv ====
`timescale 1ns/1ps

module mshr_buffer
    import cache_types_pkg::*;
#(
    parameter int NUM_SETS = 4
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  addr_t                   req_addr,
    input  word_t                   req_wdata,
    input  uuid_t                   req_uuid,
    input  logic                    lookup_hit,
    input  logic                    hit_queue_full,
    input  logic                    halt,
    input  logic                    busy,
    input  logic                    release_mshr,
    output logic                    req_ready,
    output logic                    mshr_valid,
    output addr_t                   mshr_block_addr,
    output uuid_t                   mshr_uuid,
    output logic [BLOCK_WORDS-1:0]  mshr_write_status,
    output word_t [BLOCK_WORDS-1:0] mshr_write_block
);
    localparam int IDX_W   = $clog2(NUM_SETS);
    localparam int BLK_LSB = OFFSET_W + BYTE_OFF_W;
    localparam int TAG_W   = ADDR_W - IDX_W - BLK_LSB;

    logic [OFFSET_W-1:0] req_off;
    logic                same_block;
    logic                merge_ok;
    logic                capture_ok;
    logic                miss_take;

    assign req_off    = req_addr[BYTE_OFF_W +: OFFSET_W];
    assign same_block = mshr_valid
                        && (req_addr[ADDR_W-1 -: TAG_W] == mshr_block_addr[ADDR_W-1 -: TAG_W])
                        && (req_addr[BLK_LSB +: IDX_W] == mshr_block_addr[BLK_LSB +: IDX_W]);

    // No merge while the bank installs the block
    assign merge_ok   = req_write && same_block && !release_mshr;
    assign capture_ok = !mshr_valid && !busy;
    assign req_ready  = !halt && !hit_queue_full && (lookup_hit || merge_ok || capture_ok);
    assign miss_take  = req_valid && req_ready && !lookup_hit;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mshr_valid        <= 1'b0;
            mshr_write_status <= '0;
        end else if (miss_take && !mshr_valid) begin
            mshr_valid        <= 1'b1;
            mshr_write_status <= req_write ? (BLOCK_WORDS'(1) << req_off) : '0;
        end else if (miss_take) begin
            mshr_write_status[req_off] <= 1'b1;  // Merged store
        end else if (release_mshr) begin
            mshr_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (miss_take && !mshr_valid) begin
            mshr_block_addr <= {req_addr[ADDR_W-1:BLK_LSB], BLK_LSB'(0)};
            mshr_uuid       <= req_uuid;
        end
        if (miss_take && req_write) begin
            mshr_write_block[req_off] <= req_wdata;
        end
    end

endmodule

// ==== cache_bank/bank_lru.sv ====
`timescale 1ns/1ps

module bank_lru #(
    parameter int NUM_SETS = 4,
    parameter int NUM_WAYS = 2,
    localparam int SET_W   = $clog2(NUM_SETS),
    localparam int WAY_W   = $clog2(NUM_WAYS)
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             touch,
    input  logic [SET_W-1:0] touch_set,
    input  logic [WAY_W-1:0] touch_way,
    input  logic [SET_W-1:0] victim_set,
    output logic [WAY_W-1:0] victim_way
);
    localparam int AGE_W = WAY_W + 1;

    logic [AGE_W-1:0] age_q [NUM_SETS][NUM_WAYS];
    logic [AGE_W-1:0] oldest;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            age_q <= '{default: '0};
        end else if (touch) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (WAY_W'(w) == touch_way) begin
                    age_q[touch_set][w] <= '0;
                end else if (age_q[touch_set][w] != '1) begin  // Saturate
                    age_q[touch_set][w] <= age_q[touch_set][w] + 1'b1;
                end
            end
        end
    end

    // Oldest way wins, lowest index on ties
    always_comb begin
        victim_way = '0;
        oldest     = age_q[victim_set][0];
        for (int w = 1; w < NUM_WAYS; w++) begin
            if (age_q[victim_set][w] > oldest) begin
                oldest     = age_q[victim_set][w];
                victim_way = WAY_W'(w);
            end
        end
    end

endmodule

// ==== cache_bank/cache_bank.sv ====
`timescale 1ns/1ps

module cache_bank
    import cache_types_pkg::*;
#(
    parameter int NUM_SETS = 4,
    parameter int NUM_WAYS = 2
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    req_valid,
    input  logic                    req_ready,
    input  logic                    req_write,
    input  addr_t                   req_addr,
    input  word_t                   req_wdata,
    input  logic                    halt,
    input  logic                    mshr_valid,
    input  addr_t                   mshr_block_addr,
    input  uuid_t                   mshr_uuid,
    input  logic [BLOCK_WORDS-1:0]  mshr_write_status,
    input  word_t [BLOCK_WORDS-1:0] mshr_write_block,
    input  word_t                   ram_rdata,
    input  logic                    ram_done,
    input  logic                    done_queue_full,
    output logic                    lookup_hit,
    output logic                    load_hit,
    output word_t                   read_data,
    output logic                    busy,
    output logic                    release_mshr,
    output logic                    done_push,
    output uuid_t                   done_uuid_out,
    output logic                    ram_ren,
    output logic                    ram_wen,
    output addr_t                   ram_addr,
    output word_t                   ram_wdata,
    output logic                    flushed
);
    localparam int IDX_W   = $clog2(NUM_SETS);
    localparam int WAY_W   = $clog2(NUM_WAYS);
    localparam int BLK_LSB = OFFSET_W + BYTE_OFF_W;
    localparam int TAG_W   = ADDR_W - IDX_W - BLK_LSB;

    typedef struct packed {
        logic                    valid;
        logic                    dirty;
        logic [TAG_W-1:0]        tag;
        word_t [BLOCK_WORDS-1:0] block;
    } line_t;

    logic [NUM_WAYS-1:0]     valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0]     dirty_q [NUM_SETS];
    logic [TAG_W-1:0]        tag_q   [NUM_SETS][NUM_WAYS];
    word_t [BLOCK_WORDS-1:0] data_q  [NUM_SETS][NUM_WAYS];

    bank_state_t             state, next_state;
    logic [OFFSET_W-1:0]     word_cnt;
    logic                    last_word;
    logic [IDX_W-1:0]        vic_set;
    logic [WAY_W-1:0]        vic_way;
    line_t                   vic_line;    // Copy of the line being replaced
    word_t [BLOCK_WORDS-1:0] pull_block;
    word_t [BLOCK_WORDS-1:0] fill_block;
    logic [IDX_W+WAY_W-1:0]  flush_idx;
    logic [IDX_W-1:0]        flush_set;
    logic [WAY_W-1:0]        flush_way;

    logic [IDX_W-1:0]        req_set, mshr_set;
    logic [TAG_W-1:0]        req_tag, mshr_tag;
    logic [OFFSET_W-1:0]     req_off;
    logic [WAY_W-1:0]        hit_way, lru_victim;
    logic                    victim_lock, hit_fire, finish_fire;

    assign req_set   = req_addr[BLK_LSB +: IDX_W];
    assign req_tag   = req_addr[ADDR_W-1 -: TAG_W];
    assign req_off   = req_addr[BYTE_OFF_W +: OFFSET_W];
    assign mshr_set  = mshr_block_addr[BLK_LSB +: IDX_W];
    assign mshr_tag  = mshr_block_addr[ADDR_W-1 -: TAG_W];
    assign flush_set = flush_idx[IDX_W-1:0];   // Sets walk fastest
    assign flush_way = flush_idx[IDX_W +: WAY_W];
    assign last_word = (word_cnt == OFFSET_W'(BLOCK_WORDS - 1));

    assign victim_lock   = (state == IDLE) && mshr_valid;
    assign hit_fire      = req_valid && req_ready && lookup_hit;
    assign load_hit      = hit_fire && !req_write;
    assign read_data     = data_q[req_set][hit_way][req_off];
    assign finish_fire   = (state == FINISH) && !done_queue_full;
    assign release_mshr  = finish_fire;
    assign done_push     = finish_fire;
    assign done_uuid_out = mshr_uuid;
    assign busy          = (state != IDLE);

    // The victim is no longer hittable once the miss is latched
    always_comb begin
        lookup_hit = 1'b0;
        hit_way    = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[req_set][w] && (tag_q[req_set][w] == req_tag)
                && !(victim_lock && (req_set == mshr_set) && (WAY_W'(w) == lru_victim))) begin
                lookup_hit = 1'b1;
                hit_way    = WAY_W'(w);
            end
        end
    end

    always_comb begin
        for (int w = 0; w < BLOCK_WORDS; w++) begin
            fill_block[w] = mshr_write_status[w] ? mshr_write_block[w] : pull_block[w];
        end
    end

    always_comb begin
        ram_ren   = 1'b0;
        ram_wen   = 1'b0;
        ram_addr  = '0;
        ram_wdata = '0;
        case (state)
            BLOCK_PULL: begin
                ram_ren  = 1'b1;
                ram_addr = {mshr_tag, vic_set, word_cnt, BYTE_OFF_W'(0)};
            end
            VICTIM_EJECT: begin
                ram_wen   = 1'b1;
                ram_addr  = {vic_line.tag, vic_set, word_cnt, BYTE_OFF_W'(0)};
                ram_wdata = vic_line.block[word_cnt];
            end
            WRITEBACK: begin
                ram_wen   = 1'b1;
                ram_addr  = {tag_q[flush_set][flush_way], flush_set, word_cnt, BYTE_OFF_W'(0)};
                ram_wdata = data_q[flush_set][flush_way][word_cnt];
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (mshr_valid) next_state = BLOCK_PULL;
                else if (halt) next_state = FLUSH;
            end
            BLOCK_PULL: begin
                if (ram_done && last_word) begin
                    next_state = (vic_line.valid && vic_line.dirty) ? VICTIM_EJECT : FINISH;
                end
            end
            VICTIM_EJECT: if (ram_done && last_word) next_state = FINISH;
            FINISH: if (!done_queue_full) next_state = IDLE;  // Held by done queue
            FLUSH: begin
                if (valid_q[flush_set][flush_way] && dirty_q[flush_set][flush_way]) begin
                    next_state = WRITEBACK;
                end else if (&flush_idx) begin
                    next_state = HALTED;
                end
            end
            WRITEBACK: if (ram_done && last_word) next_state = FLUSH;
            HALTED: if (!halt) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            word_cnt  <= '0;
            vic_set   <= '0;
            vic_way   <= '0;
            flush_idx <= '0;
            flushed   <= 1'b0;
        end else begin
            state   <= next_state;
            flushed <= (state == FLUSH) && (next_state == HALTED);
            if (ram_done && (ram_ren || ram_wen)) word_cnt <= word_cnt + 1'b1;  // Wraps per block
            if (victim_lock) begin
                vic_set <= mshr_set;
                vic_way <= lru_victim;
            end
            if (state == IDLE) flush_idx <= '0;
            else if ((state == FLUSH) && (next_state == FLUSH)) flush_idx <= flush_idx + 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
        end else begin
            if (hit_fire && req_write) dirty_q[req_set][hit_way] <= 1'b1;
            if (victim_lock) valid_q[mshr_set][lru_victim] <= 1'b0;
            if (finish_fire) begin
                valid_q[vic_set][vic_way] <= 1'b1;
                dirty_q[vic_set][vic_way] <= |mshr_write_status;
            end
            if ((state == FLUSH) && (next_state != WRITEBACK)) begin
                valid_q[flush_set][flush_way] <= 1'b0;
                dirty_q[flush_set][flush_way] <= 1'b0;
            end
            if ((state == WRITEBACK) && ram_done && last_word) begin
                dirty_q[flush_set][flush_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (hit_fire && req_write) data_q[req_set][hit_way][req_off] <= req_wdata;
        if (finish_fire) begin
            tag_q[vic_set][vic_way]  <= mshr_tag;
            data_q[vic_set][vic_way] <= fill_block;
        end
        if (victim_lock) begin
            vic_line <= '{valid: valid_q[mshr_set][lru_victim],
                          dirty: dirty_q[mshr_set][lru_victim],
                          tag:   tag_q[mshr_set][lru_victim],
                          block: data_q[mshr_set][lru_victim]};
        end
        if ((state == BLOCK_PULL) && ram_done) pull_block[word_cnt] <= ram_rdata;
    end

    bank_lru #(
        .NUM_SETS(NUM_SETS),
        .NUM_WAYS(NUM_WAYS)
    ) i_lru (
        .CLK       (CLK),
        .nRST      (nRST),
        .touch     (hit_fire || finish_fire),
        .touch_set (finish_fire ? vic_set : req_set),  // Install outranks a hit
        .touch_way (finish_fire ? vic_way : hit_way),
        .victim_set(mshr_set),
        .victim_way(lru_victim)
    );

endmodule

// ==== design/resp_fifo.sv ====
`timescale 1ns/1ps

module resp_fifo #(
    parameter type payload_t  = logic,
    parameter int  FIFO_DEPTH = 4
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push, do_pop;

    assign full      = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign do_push   = push && !full;  // Dropped only if caller ignores full
    assign do_pop    = out_valid && out_ready;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
        end
    end

    always_ff @(posedge CLK) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

// ==== design/cache_subsystem_top.sv ====
`timescale 1ns/1ps

module cache_subsystem_top
    import cache_types_pkg::*;
#(
    parameter int NUM_SETS   = 4,
    parameter int NUM_WAYS   = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  req_valid,
    input  logic  req_write,
    input  addr_t req_addr,
    input  word_t req_wdata,
    input  uuid_t req_uuid,
    output logic  req_ready,
    output logic  ram_ren,
    output logic  ram_wen,
    output addr_t ram_addr,
    output word_t ram_wdata,
    input  word_t ram_rdata,
    input  logic  ram_done,
    output logic  hit_valid,
    output uuid_t hit_uuid,
    output word_t hit_data,
    input  logic  hit_ready,
    output logic  done_valid,
    output uuid_t done_uuid,
    input  logic  done_ready,
    input  logic  halt,
    output logic  flushed
);
    typedef struct packed {
        uuid_t uuid;
        word_t data;
    } hit_entry_t;

    logic                    lookup_hit, load_hit, busy, release_mshr, done_push;
    logic                    hit_queue_full, done_queue_full;
    logic                    mshr_valid;
    addr_t                   mshr_block_addr;
    uuid_t                   mshr_uuid, done_uuid_out;
    logic [BLOCK_WORDS-1:0]  mshr_write_status;
    word_t [BLOCK_WORDS-1:0] mshr_write_block;
    word_t                   read_data;
    hit_entry_t              hit_out;

    assign hit_uuid = hit_out.uuid;
    assign hit_data = hit_out.data;

    mshr_buffer #(
        .NUM_SETS(NUM_SETS)
    ) i_mshr (
        .CLK              (CLK),
        .nRST             (nRST),
        .req_valid        (req_valid),
        .req_write        (req_write),
        .req_addr         (req_addr),
        .req_wdata        (req_wdata),
        .req_uuid         (req_uuid),
        .lookup_hit       (lookup_hit),
        .hit_queue_full   (hit_queue_full),
        .halt             (halt),
        .busy             (busy),
        .release_mshr     (release_mshr),
        .req_ready        (req_ready),
        .mshr_valid       (mshr_valid),
        .mshr_block_addr  (mshr_block_addr),
        .mshr_uuid        (mshr_uuid),
        .mshr_write_status(mshr_write_status),
        .mshr_write_block (mshr_write_block)
    );

    cache_bank #(
        .NUM_SETS(NUM_SETS),
        .NUM_WAYS(NUM_WAYS)
    ) i_bank (
        .CLK              (CLK),
        .nRST             (nRST),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .req_write        (req_write),
        .req_addr         (req_addr),
        .req_wdata        (req_wdata),
        .halt             (halt),
        .mshr_valid       (mshr_valid),
        .mshr_block_addr  (mshr_block_addr),
        .mshr_uuid        (mshr_uuid),
        .mshr_write_status(mshr_write_status),
        .mshr_write_block (mshr_write_block),
        .ram_rdata        (ram_rdata),
        .ram_done         (ram_done),
        .done_queue_full  (done_queue_full),
        .lookup_hit       (lookup_hit),
        .load_hit         (load_hit),
        .read_data        (read_data),
        .busy             (busy),
        .release_mshr     (release_mshr),
        .done_push        (done_push),
        .done_uuid_out    (done_uuid_out),
        .ram_ren          (ram_ren),
        .ram_wen          (ram_wen),
        .ram_addr         (ram_addr),
        .ram_wdata        (ram_wdata),
        .flushed          (flushed)
    );

    resp_fifo #(
        .payload_t (hit_entry_t),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) hit_queue (
        .CLK      (CLK),
        .nRST     (nRST),
        .push     (load_hit),
        .push_data(hit_entry_t'{uuid: req_uuid, data: read_data}),
        .full     (hit_queue_full),
        .out_valid(hit_valid),
        .out_data (hit_out),
        .out_ready(hit_ready)
    );

    resp_fifo #(
        .payload_t (uuid_t),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) done_queue (
        .CLK      (CLK),
        .nRST     (nRST),
        .push     (done_push),
        .push_data(done_uuid_out),
        .full     (done_queue_full),
        .out_valid(done_valid),
        .out_data (done_uuid),
        .out_ready(done_ready)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 8
) (
    output logic CLK,
    output logic nRST
);
    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (RST_CYCLES) @(posedge CLK);
        #2 nRST = 1'b1;  // Released off the edge like other inputs
    end

endmodule

// ==== testbench/cache_subsystem_props.sv ====
`timescale 1ns/1ps

module cache_subsystem_props
    import cache_types_pkg::*;
(
    input logic  CLK,
    input logic  nRST,
    input logic  ram_ren,
    input logic  ram_wen,
    input addr_t ram_addr,
    input word_t ram_wdata,
    input logic  ram_done,
    input logic  flushed,
    input logic  done_valid,
    input logic  done_ready,
    input uuid_t done_uuid
);
    int fail_count = 0;  // Polled by the testbench top

    ram_one_direction: assert property (@(posedge CLK) disable iff (!nRST)
        !(ram_ren && ram_wen))
    else begin
        fail_count = fail_count + 1;
        $error("RAM read and write enables high together");
    end

    // A waiting RAM request must not move
    ram_request_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (ram_ren || ram_wen) && !ram_done |=>
            $stable(ram_ren) && $stable(ram_wen) && $stable(ram_addr) && $stable(ram_wdata))
    else begin
        fail_count = fail_count + 1;
        $error("RAM request changed before ram_done");
    end

    flushed_single_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        flushed |=> !flushed)
    else begin
        fail_count = fail_count + 1;
        $error("flushed was high for more than one cycle");
    end

    done_held: assert property (@(posedge CLK) disable iff (!nRST)
        done_valid && !done_ready |=> done_valid && $stable(done_uuid))
    else begin
        fail_count = fail_count + 1;
        $error("done response dropped or changed before done_ready");
    end

endmodule

// ==== testbench/tb_cache_subsystem.sv ====
`timescale 1ns/1ps

module tb_cache_subsystem
    import cache_types_pkg::*;
;
    localparam int MEM_WORDS = 1024;
    localparam int DRIVE_DLY = 2;
    localparam int TIMEOUT   = 300;

    logic  CLK, nRST;
    logic  req_valid, req_write, req_ready;
    addr_t req_addr;
    word_t req_wdata;
    uuid_t req_uuid;
    logic  ram_ren, ram_wen, ram_done;
    addr_t ram_addr;
    word_t ram_wdata, ram_rdata;
    logic  hit_valid, hit_ready, done_valid, done_ready;
    uuid_t hit_uuid, done_uuid;
    word_t hit_data;
    logic  halt, flushed;

    word_t ram_mem [MEM_WORDS];
    word_t shadow  [MEM_WORDS];  // RAM contents plus every accepted store
    uuid_t exp_uuid [$];
    word_t exp_data [$];

    tb_clock_gen i_clk (
        .CLK (CLK),
        .nRST(nRST)
    );

    cache_subsystem_top #(
        .NUM_SETS  (4),
        .NUM_WAYS  (2),
        .FIFO_DEPTH(4)
    ) i_dut (.*);

    bind cache_subsystem_top cache_subsystem_props i_props (.*);

    function automatic int word_index(input addr_t addr);
        return int'(addr[11:2]);
    endfunction

    function automatic word_t init_word(input int idx);
        return {idx[29:0], 2'b00} ^ 32'h5A3C_96E1;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got == exp)
        else abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic issue_request(input logic write, input addr_t addr, input word_t data,
                                 input uuid_t uuid);
        int n;
        n = 0;
        @(posedge CLK);
        #DRIVE_DLY;
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = data;
        req_uuid  = uuid;
        @(negedge CLK);
        while (!req_ready) begin
            n++;
            if (n > TIMEOUT) abort_run("request was never accepted");
            else @(negedge CLK);
        end
        if (write) shadow[word_index(addr)] = data;
        @(posedge CLK);
        #DRIVE_DLY;
        req_valid = 1'b0;
    endtask

    task automatic wait_response();
        int n;
        n = 0;
        @(negedge CLK);
        while (!hit_valid && !done_valid) begin
            n++;
            if (n > TIMEOUT) abort_run("no response arrived for the request");
            else @(negedge CLK);
        end
    endtask

    task automatic expect_hit(input uuid_t uuid, input addr_t addr);
        wait_response();
        assert (hit_valid) else abort_run("load missed where a hit was expected");
        check_value("hit_uuid", hit_uuid, uuid);
        check_value("hit_data", hit_data, shadow[word_index(addr)]);
    endtask

    task automatic expect_done(input uuid_t uuid);
        wait_response();
        assert (done_valid) else abort_run("request hit where a miss was expected");
        check_value("done_uuid", done_uuid, uuid);
    endtask

    // Reissue after the miss completes, like the scheduler
    task automatic load_and_check(input addr_t addr, input uuid_t uuid, input logic want_miss);
        issue_request(1'b0, addr, '0, uuid);
        if (want_miss) begin
            expect_done(uuid);
            issue_request(1'b0, addr, '0, uuid);
        end
        expect_hit(uuid, addr);
    endtask

    task automatic drain_hits();
        int n;
        n = 0;
        while (exp_uuid.size() > 0) begin
            @(negedge CLK);
            n++;
            if (n > TIMEOUT) abort_run("queued hit responses were not delivered");
            else if (hit_valid) begin
                check_value("hit_uuid", hit_uuid, exp_uuid.pop_front());
                check_value("hit_data", hit_data, exp_data.pop_front());
            end
        end
    endtask

    initial begin : ram_model
        int cycles_left;
        cycles_left = 0;
        ram_done    = 1'b0;
        ram_rdata   = '0;
        void'($urandom(46));
        forever begin
            @(posedge CLK);
            #DRIVE_DLY;
            ram_done = 1'b0;
            if (nRST && (ram_ren || ram_wen)) begin
                if (cycles_left == 0) cycles_left = $urandom_range(4, 1);
                cycles_left--;
                if (cycles_left == 0) begin
                    if (ram_wen) begin
                        check_value("ram_wdata", ram_wdata, shadow[word_index(ram_addr)]);
                        ram_mem[word_index(ram_addr)] = ram_wdata;
                    end else begin
                        ram_rdata = ram_mem[word_index(ram_addr)];
                    end
                    ram_done = 1'b1;
                end
            end
        end
    end

    always @(negedge CLK) begin
        if (i_dut.i_props.fail_count != 0) abort_run("a protocol assertion failed");
    end

    initial begin
        int n;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_uuid   = '0;
        hit_ready  = 1'b1;
        done_ready = 1'b1;
        halt       = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ram_mem[i] = init_word(i);
            shadow[i]  = init_word(i);
        end
        n = 0;
        while (nRST !== 1'b1) begin
            n++;
            if (n > 20) abort_run("reset was never released");
            else @(posedge CLK);
        end
        @(negedge CLK);
        check_value("req_ready", req_ready, 1'b1);
        assert (!ram_ren && !ram_wen && !hit_valid && !done_valid && !flushed)
        else abort_run("outputs not idle after reset");

        // Load miss, then reissue hits
        load_and_check(32'h110, 4'd1, 1'b1);
        load_and_check(32'h114, 4'd2, 1'b0);

        // Store hit, and a store merged into a pending miss
        issue_request(1'b1, 32'h118, 32'hCAFE_0001, 4'd3);
        load_and_check(32'h118, 4'd4, 1'b0);
        issue_request(1'b0, 32'h120, '0, 4'd5);
        issue_request(1'b1, 32'h128, 32'h1234_ABCD, 4'd6);
        expect_done(4'd5);
        issue_request(1'b0, 32'h120, '0, 4'd5);
        expect_hit(4'd5, 32'h120);
        load_and_check(32'h128, 4'd7, 1'b0);

        // Set 0 gets three blocks, B dirty and least recent
        load_and_check(32'h200, 4'd8, 1'b1);
        @(posedge CLK);
        #DRIVE_DLY;
        done_ready = 1'b0;  // Completion waits in the done queue
        issue_request(1'b1, 32'h244, 32'hBEEF_0244, 4'd9);
        expect_done(4'd9);
        @(posedge CLK);
        #DRIVE_DLY;
        done_ready = 1'b1;
        load_and_check(32'h200, 4'd10, 1'b0);
        load_and_check(32'h28C, 4'd11, 1'b1);
        load_and_check(32'h204, 4'd12, 1'b0);
        load_and_check(32'h244, 4'd13, 1'b1);
        issue_request(1'b1, 32'h208, 32'h0DD0_0208, 4'd14);

        // Hit queue back-pressure
        @(posedge CLK);
        #DRIVE_DLY;
        hit_ready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            issue_request(1'b0, 32'h200 + 32'(4 * i), '0, uuid_t'(i));
            exp_uuid.push_back(uuid_t'(i));
            exp_data.push_back(shadow[word_index(32'h200 + 32'(4 * i))]);
        end
        @(posedge CLK);
        #DRIVE_DLY;
        req_valid = 1'b1;
        req_write = 1'b0;
        req_addr  = 32'h110;
        req_uuid  = 4'd4;
        @(negedge CLK);
        assert (!req_ready) else abort_run("req_ready stayed high with the hit queue full");
        @(posedge CLK);
        #DRIVE_DLY;
        req_valid = 1'b0;
        hit_ready = 1'b1;
        drain_hits();
        load_and_check(32'h110, 4'd4, 1'b0);

        // Flush on halt
        @(posedge CLK);
        #DRIVE_DLY;
        halt = 1'b1;
        n = 0;
        @(negedge CLK);
        while (!flushed) begin
            n++;
            if (n > 2 * TIMEOUT) abort_run("flushed never pulsed after halt");
            else @(negedge CLK);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("ram word %0d", i), ram_mem[i], shadow[i]);
        end
        @(posedge CLK);
        #DRIVE_DLY;
        halt = 1'b0;
        load_and_check(32'h200, 4'd15, 1'b1);
        load_and_check(32'h118, 4'd0, 1'b1);
        load_and_check(32'h128, 4'd1, 1'b1);
        load_and_check(32'h244, 4'd2, 1'b1);

        repeat (2) @(posedge CLK);
        if (i_dut.i_props.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run("a protocol assertion failed");
        end
    end

endmodule

// ==== all.f ====
common/cache_types_pkg.sv
design/mshr_buffer.sv
cache_bank/bank_lru.sv
cache_bank/cache_bank.sv
design/resp_fifo.sv
design/cache_subsystem_top.sv
testbench/tb_clock_gen.sv
testbench/cache_subsystem_props.sv
testbench/tb_cache_subsystem.sv
